//--- dv/blur_sram_model.sv
`timescale 1ns/10ps

module blur_sram_model (
  input  logic                  clk,
  input  blur_pkg::mem_rd_t     rd,
  input  blur_pkg::mem_wr_t     wr,
  output blur_pkg::row_word_t   dout
);

  // one row word per image row
  blur_pkg::row_word_t mem [blur_pkg::IMG_ROWS];

  // registered read, held until the address changes
  always @(posedge clk) begin
    if (wr.we) begin
      mem[wr.addr] <= wr.data;
    end
    // read returns the old row on a same-address write
    dout <= mem[rd.addr];
  end

endmodule

//--- dv/gauss_blur_tb.sv
`timescale 1ns/10ps

module gauss_blur_tb;

  localparam int CLK_PERIOD = 40;
  localparam int RUN_CYCLES =
    blur_pkg::NUM_STRIPS * (blur_pkg::IMG_ROWS + 2) * 4 + 2;
  localparam int NUM_RUNS   = 5;
  // reset, every run with some slack, plus margin
  localparam int WATCHDOG_NS = (8 + NUM_RUNS * (RUN_CYCLES + 30) + 200) * CLK_PERIOD;

  logic                  clk;
  logic                  rst_n;
  logic                  start;
  logic                  done;
  blur_pkg::mem_rd_t     img_rd;
  blur_pkg::row_word_t   img_dout;
  blur_pkg::mem_wr_t     img_wr;
  blur_pkg::mem_rd_t     k3_rd;
  blur_pkg::row_word_t   k3_dout;
  blur_pkg::mem_wr_t     k3_wr;
  blur_pkg::mem_rd_t     k5_rd;
  blur_pkg::row_word_t   k5_dout;
  blur_pkg::mem_wr_t     k5_wr;

  blur_pkg::pix_t img [blur_pkg::IMG_ROWS][blur_pkg::IMG_COLS];
  integer seed;

  // image memory is read only
  assign img_wr = '0;

  gauss_blur_top dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .done     (done),
    .img_rd   (img_rd),
    .img_dout (img_dout),
    .k3_rd    (k3_rd),
    .k3_dout  (k3_dout),
    .k3_wr    (k3_wr),
    .k5_rd    (k5_rd),
    .k5_dout  (k5_dout),
    .k5_wr    (k5_wr)
  );

  blur_sram_model img_mem (.clk(clk), .rd(img_rd), .wr(img_wr), .dout(img_dout));
  blur_sram_model k3_mem (.clk(clk), .rd(k3_rd), .wr(k3_wr), .dout(k3_dout));
  blur_sram_model k5_mem (.clk(clk), .rd(k5_rd), .wr(k5_wr), .dout(k5_dout));

  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests completed");
    $display("CHECKS FAILED");
    $fatal(1, "timeout");
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // binomial row 1 2 1 or 1 4 6 4 1
  function automatic int binom(input int ksize, input int i);
    int w3 [3];
    int w5 [5];
    w3 = '{1, 2, 1};
    w5 = '{1, 4, 6, 4, 1};
    if (ksize == 3) begin
      return w3[i];
    end else begin
      return w5[i];
    end
  endfunction

  // reference blur with zero padding and truncating divide
  function automatic int ref_blur(input int ksize, input int r, input int c);
    int half;
    int sum;
    int rr;
    int cc;
    half = ksize / 2;
    sum  = 0;
    for (int dy = 0; dy < ksize; dy++) begin
      for (int dx = 0; dx < ksize; dx++) begin
        rr = r + dy - half;
        cc = c + dx - half;
        if (rr >= 0 && rr < blur_pkg::IMG_ROWS && cc >= 0 && cc < blur_pkg::IMG_COLS) begin
          sum += binom(ksize, dy) * binom(ksize, dx) * int'(img[rr][cc]);
        end
      end
    end
    return (ksize == 3) ? sum / 16 : sum / 256;
  endfunction

  task automatic load_image();
    blur_pkg::row_word_t w;
    for (int r = 0; r < blur_pkg::IMG_ROWS; r++) begin
      for (int c = 0; c < blur_pkg::IMG_COLS; c++) begin
        w[c] = img[r][c];
      end
      img_mem.mem[r] = w;
    end
  endtask

  // stale pattern in the result rows, unique per row and column
  task automatic prefill_results(input logic [7:0] key);
    blur_pkg::row_word_t w;
    for (int r = 0; r < blur_pkg::IMG_ROWS; r++) begin
      for (int c = 0; c < blur_pkg::IMG_COLS; c++) begin
        w[c] = 8'(r * blur_pkg::IMG_COLS + c) ^ key;
      end
      k3_mem.mem[r] = w;
      k5_mem.mem[r] = ~w;
    end
  endtask

  task automatic fill_flat(input logic [7:0] value);
    for (int r = 0; r < blur_pkg::IMG_ROWS; r++) begin
      for (int c = 0; c < blur_pkg::IMG_COLS; c++) begin
        img[r][c] = value;
      end
    end
  endtask

  task automatic fill_random();
    for (int r = 0; r < blur_pkg::IMG_ROWS; r++) begin
      for (int c = 0; c < blur_pkg::IMG_COLS; c++) begin
        img[r][c] = 8'($random(seed));
      end
    end
  endtask

  // pulse start, optionally poke start again at a given cycle, wait for done
  task automatic run_blur(input int poke_cycle);
    int cycles;
    start = 1'b1;
    @(negedge clk);
    start  = 1'b0;
    cycles = 1;
    while (!done) begin
      if (cycles > RUN_CYCLES + 16) begin
        $display("done did not rise within %0d cycles of start", cycles);
        $display("CHECKS FAILED");
        $fatal(1, "run timeout");
      end
      start = (cycles == poke_cycle);
      @(negedge clk);
      cycles++;
    end
    start = 1'b0;
    check("run_cycles", cycles, RUN_CYCLES);
  endtask

  task automatic compare_all();
    for (int r = 0; r < blur_pkg::IMG_ROWS; r++) begin
      for (int c = 0; c < blur_pkg::IMG_COLS; c++) begin
        check($sformatf("k3[%0d][%0d]", r, c), k3_mem.mem[r][c], ref_blur(3, r, c));
        check($sformatf("k5[%0d][%0d]", r, c), k5_mem.mem[r][c], ref_blur(5, r, c));
      end
    end
  endtask

  task automatic test_reset();
    check("done", done, 0);
    check("k3_wr.we", k3_wr.we, 0);
    check("k5_wr.we", k5_wr.we, 0);
  endtask

  task automatic test_flat();
    fill_flat(8'd100);
    load_image();
    prefill_results(8'h5a);
    run_blur(0);
    compare_all();
    check("k3[8][8]", k3_mem.mem[8][8], 100);
    check("k5[8][8]", k5_mem.mem[8][8], 100);
    // corner keeps 3x3 of 16 and 121 of 256
    check("k3[0][0]", k3_mem.mem[0][0], 56);
    check("k5[0][0]", k5_mem.mem[0][0], 47);
    check("k3[0][8]", k3_mem.mem[0][8], 75);
    check("k5[0][8]", k5_mem.mem[0][8], 68);
    check("k5[1][1]", k5_mem.mem[1][1], 87);
  endtask

  task automatic test_boundary();
    int row;
    int col;
    fill_flat(8'd0);
    // last pixel of a strip on row 3, first pixel of the next on row 11
    for (int b = 1; b < blur_pkg::NUM_STRIPS; b++) begin
      img[3][b * blur_pkg::STRIP_PX - 1] = 8'd255;
      img[11][b * blur_pkg::STRIP_PX]    = 8'd255;
    end
    load_image();
    prefill_results(8'h3c);
    run_blur(0);
    compare_all();
    for (int b = 1; b < blur_pkg::NUM_STRIPS; b++) begin
      row = 3;
      col = b * blur_pkg::STRIP_PX - 1;
      check($sformatf("k3[%0d][%0d]", row, col), k3_mem.mem[row][col], 63);
      check($sformatf("k5[%0d][%0d]", row, col), k5_mem.mem[row][col], 35);
      // neighbours in the next strip
      check($sformatf("k3[%0d][%0d]", row, col + 1), k3_mem.mem[row][col + 1], 31);
      // bright pixels two columns away on both sides, only one after the last strip
      check($sformatf("k5[%0d][%0d]", row, col + 2), k5_mem.mem[row][col + 2],
            (b < blur_pkg::NUM_STRIPS - 1) ? 11 : 5);
      row = 11;
      col = b * blur_pkg::STRIP_PX;
      check($sformatf("k3[%0d][%0d]", row, col - 1), k3_mem.mem[row][col - 1], 31);
      check($sformatf("k5[%0d][%0d]", row, col - 1), k5_mem.mem[row][col - 1], 23);
    end
  endtask

  task automatic test_random();
    fill_random();
    load_image();
    prefill_results(8'ha7);
    run_blur(0);
    compare_all();
  endtask

  task automatic test_overwrite_restart();
    fill_random();
    load_image();
    prefill_results(8'hff);
    // start while busy must not restart
    run_blur(100);
    compare_all();
    fill_random();
    load_image();
    prefill_results(8'h00);
    // start in the drain cycle must not restart either
    run_blur(RUN_CYCLES - 1);
    compare_all();
    repeat (8) begin
      @(negedge clk);
      check("done", done, 1);
      check("k3_wr.we", k3_wr.we, 0);
      check("k5_wr.we", k5_wr.we, 0);
    end
  endtask

  initial begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    start   = 1'b0;
    seed    = 32'he3edd45f;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_reset();
    test_flat();
    test_boundary();
    test_random();
    test_overwrite_restart();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- src/blur_ctrl.sv
`timescale 1ns/10ps

module blur_ctrl (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               start,
  output logic                               done,
  output blur_pkg::mem_rd_t                  img_rd,
  output blur_pkg::mem_rd_t                  res_rd,
  output logic                               shift,
  output logic                               row_valid,
  output logic                               calc,
  output logic                               wr_stb,
  output logic [blur_pkg::ADDR_W-1:0]        out_row,
  output logic [blur_pkg::STRIP_IDX_W-1:0]   strip_idx
);

  blur_pkg::step_t                     state;
  logic [blur_pkg::STEP_W-1:0]         row_cnt;
  logic [blur_pkg::STRIP_IDX_W-1:0]    strip_cnt;
  // one cycle after the last write, lets the final write land first
  logic                                finish;
  logic                                last_step;
  logic                                last_strip;
  logic                                filling;

  assign last_step  = (row_cnt == blur_pkg::STEP_W'(blur_pkg::STEPS_PER_STRIP - 1));
  assign last_strip = (strip_cnt == blur_pkg::STRIP_IDX_W'(blur_pkg::NUM_STRIPS - 1));

  // window not yet centred on an image row
  assign filling    = (row_cnt < blur_pkg::STEP_W'(blur_pkg::HALO));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= blur_pkg::ST_IDLE;
      row_cnt   <= '0;
      strip_cnt <= '0;
      finish    <= 1'b0;
      done      <= 1'b0;
    end else begin
      finish <= 1'b0;
      if (finish) begin
        done <= 1'b1;
      end
      case (state)
        blur_pkg::ST_IDLE: begin
          // start is ignored in the drain cycle too
          if (start && !finish) begin
            done    <= 1'b0;
            row_cnt <= '0;
            state   <= blur_pkg::ST_READ;
          end
        end
        blur_pkg::ST_READ: begin
          state <= blur_pkg::ST_SHIFT;
        end
        blur_pkg::ST_SHIFT: begin
          state <= blur_pkg::ST_CALC;
        end
        blur_pkg::ST_CALC: begin
          state <= blur_pkg::ST_WRITE;
        end
        blur_pkg::ST_WRITE: begin
          if (last_step) begin
            row_cnt <= '0;
            // wraps to 0 after the last strip, window sees the change
            strip_cnt <= strip_cnt + 1'b1;
            if (last_strip) begin
              finish <= 1'b1;
              state  <= blur_pkg::ST_IDLE;
            end else begin
              state <= blur_pkg::ST_READ;
            end
          end else begin
            row_cnt <= row_cnt + 1'b1;
            state   <= blur_pkg::ST_READ;
          end
        end
        default: begin
          state <= blur_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // addresses stay put for the whole step so dout is held
  assign img_rd.addr = row_cnt[blur_pkg::ADDR_W-1:0];

  // output row lags the loaded row by the halo
  assign out_row     = blur_pkg::ADDR_W'(row_cnt - blur_pkg::STEP_W'(blur_pkg::HALO));
  assign res_rd.addr = out_row;

  // trailing steps feed zero rows below the image
  assign row_valid = (row_cnt < blur_pkg::STEP_W'(blur_pkg::IMG_ROWS));

  assign shift     = (state == blur_pkg::ST_SHIFT);
  assign calc      = (state == blur_pkg::ST_CALC) && !filling;
  assign wr_stb    = (state == blur_pkg::ST_WRITE) && !filling;
  assign strip_idx = strip_cnt;

endmodule

//--- src/blur_pkg.sv
package blur_pkg;

  // image geometry
  localparam int PIX_W       = 8;
  localparam int IMG_COLS    = 16;
  localparam int IMG_ROWS    = 16;
  localparam int STRIP_PX    = 4;
  localparam int NUM_STRIPS  = IMG_COLS / STRIP_PX;

  // halo of the largest kernel on each side of a strip
  localparam int HALO        = 2;
  localparam int WIN_ROWS    = 5;
  localparam int WIN_PX      = STRIP_PX + 2 * HALO;

  localparam int ADDR_W      = 4;
  localparam int STRIP_IDX_W = 2;

  // row steps per strip, the last HALO steps push zero rows
  localparam int STEPS_PER_STRIP = IMG_ROWS + HALO;
  localparam int STEP_W          = 5;

  typedef logic [PIX_W-1:0] pix_t;

  // pixel c of a row sits at index c
  typedef pix_t [IMG_COLS-1:0] row_word_t;
  typedef pix_t [STRIP_PX-1:0] strip_t;
  typedef pix_t [WIN_PX-1:0]   win_row_t;

  // window row 0 is the oldest (top) row
  typedef win_row_t [WIN_ROWS-1:0] win_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } mem_rd_t;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    row_word_t         data;
  } mem_wr_t;

  // phases of one row step
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ,
    ST_SHIFT,
    ST_CALC,
    ST_WRITE
  } step_t;

endpackage

//--- src/gauss_blur_top.sv
`timescale 1ns/10ps

module gauss_blur_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  output logic                  done,
  output blur_pkg::mem_rd_t     img_rd,
  input  blur_pkg::row_word_t   img_dout,
  output blur_pkg::mem_rd_t     k3_rd,
  input  blur_pkg::row_word_t   k3_dout,
  output blur_pkg::mem_wr_t     k3_wr,
  output blur_pkg::mem_rd_t     k5_rd,
  input  blur_pkg::row_word_t   k5_dout,
  output blur_pkg::mem_wr_t     k5_wr
);

  blur_pkg::mem_rd_t                  res_rd;
  logic                               shift;
  logic                               row_valid;
  logic                               calc;
  logic                               wr_stb;
  logic [blur_pkg::ADDR_W-1:0]        out_row;
  logic [blur_pkg::STRIP_IDX_W-1:0]   strip_idx;
  blur_pkg::win_t                     win;
  blur_pkg::strip_t                   k3_result;
  blur_pkg::strip_t                   k5_result;

  // both result memories read the same row
  assign k3_rd = res_rd;
  assign k5_rd = res_rd;

  blur_ctrl ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .done      (done),
    .img_rd    (img_rd),
    .res_rd    (res_rd),
    .shift     (shift),
    .row_valid (row_valid),
    .calc      (calc),
    .wr_stb    (wr_stb),
    .out_row   (out_row),
    .strip_idx (strip_idx)
  );

  strip_window window_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .shift     (shift),
    .row_valid (row_valid),
    .strip_idx (strip_idx),
    .img_dout  (img_dout),
    .win       (win)
  );

  gauss_kernel #(.KSIZE(3)) k3_kernel_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .calc   (calc),
    .win    (win),
    .result (k3_result)
  );

  gauss_kernel #(.KSIZE(5)) k5_kernel_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .calc   (calc),
    .win    (win),
    .result (k5_result)
  );

  strip_merge k3_merge_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_stb    (wr_stb),
    .out_row   (out_row),
    .strip_idx (strip_idx),
    .dout      (k3_dout),
    .result    (k3_result),
    .wr        (k3_wr)
  );

  strip_merge k5_merge_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_stb    (wr_stb),
    .out_row   (out_row),
    .strip_idx (strip_idx),
    .dout      (k5_dout),
    .result    (k5_result),
    .wr        (k5_wr)
  );

endmodule

//--- src/gauss_kernel.sv
`timescale 1ns/10ps

module gauss_kernel #(
  parameter int KSIZE = 3
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                calc,
  input  blur_pkg::win_t      win,
  output blur_pkg::strip_t    result
);

  // weights sum to 16 for 3x3 and 256 for 5x5
  localparam int SHIFT = (KSIZE == 3) ? 4 : 8;
  localparam int ACC_W = blur_pkg::PIX_W + SHIFT;

  // top-left corner of the neighbourhood inside the window
  localparam int ROW0  = blur_pkg::WIN_ROWS / 2 - KSIZE / 2;
  localparam int COL0  = blur_pkg::HALO - KSIZE / 2;

  logic [ACC_W-1:0] acc [blur_pkg::STRIP_PX];

  // one binomial coefficient
  function automatic logic [2:0] coef(input int idx);
    logic [2:0] c;
    if (KSIZE == 3) begin
      c = (idx == 1) ? 3'd2 : 3'd1;
    end else begin
      case (idx)
        0, 4:    c = 3'd1;
        1, 3:    c = 3'd4;
        default: c = 3'd6;
      endcase
    end
    return c;
  endfunction

  // outer-product weighting per strip pixel
  always_comb begin
    for (int p = 0; p < blur_pkg::STRIP_PX; p++) begin
      acc[p] = '0;
      for (int dy = 0; dy < KSIZE; dy++) begin
        for (int dx = 0; dx < KSIZE; dx++) begin
          acc[p] = acc[p] + ACC_W'(coef(dy)) * ACC_W'(coef(dx)) *
                   ACC_W'(win[ROW0 + dy][p + COL0 + dx]);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result <= '0;
    end else if (calc) begin
      for (int p = 0; p < blur_pkg::STRIP_PX; p++) begin
        // truncating divide, keep the top bits
        result[p] <= acc[p][SHIFT +: blur_pkg::PIX_W];
      end
    end
  end

endmodule

//--- src/strip_merge.sv
`timescale 1ns/10ps

module strip_merge (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               wr_stb,
  input  logic [blur_pkg::ADDR_W-1:0]        out_row,
  input  logic [blur_pkg::STRIP_IDX_W-1:0]   strip_idx,
  input  blur_pkg::row_word_t                dout,
  input  blur_pkg::strip_t                   result,
  output blur_pkg::mem_wr_t                  wr
);

  blur_pkg::row_word_t merged;

  // stored row with only the current strip replaced
  always_comb begin
    merged = dout;
    merged[strip_idx * blur_pkg::STRIP_PX +: blur_pkg::STRIP_PX] = result;
  end

  // write enable is a single-cycle pulse per strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr.we <= 1'b0;
    end else begin
      wr.we <= wr_stb;
      if (wr_stb) begin
        wr.addr <= out_row;
        wr.data <= merged;
      end
    end
  end

endmodule

//--- src/strip_window.sv
`timescale 1ns/10ps

module strip_window (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               shift,
  input  logic                               row_valid,
  input  logic [blur_pkg::STRIP_IDX_W-1:0]   strip_idx,
  input  blur_pkg::row_word_t                img_dout,
  output blur_pkg::win_t                     win
);

  localparam int PAD_PX = blur_pkg::IMG_COLS + 2 * blur_pkg::HALO;

  // row with halo zeros on both sides, image column c at index c + HALO
  logic [PAD_PX-1:0][blur_pkg::PIX_W-1:0] padded;
  blur_pkg::win_row_t                     slice;
  logic [blur_pkg::STRIP_IDX_W-1:0]       prev_strip;
  logic                                   new_strip;

  assign padded = {
    {(blur_pkg::HALO * blur_pkg::PIX_W){1'b0}},
    img_dout,
    {(blur_pkg::HALO * blur_pkg::PIX_W){1'b0}}
  };

  // strip plus halo, window column 0 is image column strip*4 - 2
  always_comb begin
    if (row_valid) begin
      slice = padded[strip_idx * blur_pkg::STRIP_PX +: blur_pkg::WIN_PX];
    end else begin
      slice = '0;
    end
  end

  assign new_strip = (strip_idx != prev_strip);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prev_strip <= '0;
    end else begin
      prev_strip <= strip_idx;
    end
  end

  // five-row shift register, newest row enters at the bottom
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win <= '0;
    end else if (new_strip) begin
      // rows above the top of the next strip read as zero
      win <= '0;
    end else if (shift) begin
      for (int r = 0; r < blur_pkg::WIN_ROWS - 1; r++) begin
        win[r] <= win[r + 1];
      end
      win[blur_pkg::WIN_ROWS - 1] <= slice;
    end
  end

endmodule

//--- vlog.f
src/blur_pkg.sv
src/blur_ctrl.sv
src/strip_window.sv
src/gauss_kernel.sv
src/strip_merge.sv
src/gauss_blur_top.sv
dv/blur_sram_model.sv
dv/gauss_blur_tb.sv
